// ==== vlog.f ====
+incdir+bench
src/of_pkg.sv
src/pkt_fifo.sv
src/pkt_preprocessor.sv
src/action_processor.sv
src/flow_tbl_ctrl.sv
src/openflow_datapath.sv
bench/tb_openflow_datapath.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_openflow_datapath -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

// ==== bench/of_model.svh ====
`ifndef OF_MODEL_SVH
`define OF_MODEL_SVH

// Reference copy of the flow table and the expected egress traffic
of_pkg::flow_entry_t model_tbl [of_pkg::TBL_DEPTH];
of_pkg::out_word_t   exp_q [of_pkg::NUM_PORTS][$];
int unsigned         exp_hit;
int unsigned         exp_miss;

task automatic check_val(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
   if (expected !== actual) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      abort_run();
   end
endtask

// First valid entry with a matching key decides
function automatic bit model_lookup(input logic [of_pkg::KEY_W-1:0] key,
                                    output of_pkg::flow_action_t act);
   act = '0;
   for (int e = 0; e < of_pkg::TBL_DEPTH; e++) begin
      if (model_tbl[e].valid && model_tbl[e].key == key) begin
         act = model_tbl[e].action;
         return 1'b1;
      end
   end
   return 1'b0;
endfunction

// Expected egress beats of one packet
task automatic model_packet(input int port, input of_pkg::stream_word_t beats [$]);
   of_pkg::flow_action_t act;
   of_pkg::pkt_hdr_t     hdr;
   of_pkg::out_word_t    ob;
   hdr = beats[0].data;
   if (!model_lookup(hdr.key, act)) begin
      exp_miss++;
      return;
   end
   exp_hit++;
   if (act.op == of_pkg::ACT_DROP) begin
      return;
   end
   foreach (beats[w]) begin
      hdr = beats[w].data;
      // Only the header word carries a tag
      if (w == 0 && act.op == of_pkg::ACT_SET_TAG) begin
         hdr.tag = act.new_tag;
      end
      ob.data     = hdr;
      ob.last     = beats[w].last;
      ob.dst_port = act.out_port;
      exp_q[port].push_back(ob);
   end
endtask

`endif

// ==== bench/tb_openflow_datapath.sv ====
`timescale 1ns/1ps

module tb_openflow_datapath;

   localparam int PKTS_SOLO   = 10;
   localparam int PKTS_BURST  = 25;
   localparam int PKTS_AFTER  = 15;
   localparam int TOTAL_PKTS  = of_pkg::NUM_PORTS * (PKTS_SOLO + PKTS_BURST + PKTS_AFTER);
   localparam int CYCLE_LIMIT = 40 * TOTAL_PKTS + 500;

   logic                         asclk = 1'b0;
   logic                         rst_n;
   of_pkg::stream_word_t         s_word [of_pkg::NUM_PORTS];
   logic [of_pkg::NUM_PORTS-1:0] s_valid;
   logic [of_pkg::NUM_PORTS-1:0] s_ready;
   of_pkg::out_word_t            m_word [of_pkg::NUM_PORTS];
   logic [of_pkg::NUM_PORTS-1:0] m_valid;
   logic [of_pkg::NUM_PORTS-1:0] m_ready;
   logic                         tbl_wr;
   logic [of_pkg::TBL_AW-1:0]    tbl_addr;
   of_pkg::flow_entry_t          tbl_entry;
   logic [of_pkg::CNT_W-1:0]     hit_count;
   logic [of_pkg::CNT_W-1:0]     miss_count;

   // Beats still waiting to enter each port
   of_pkg::stream_word_t         tx_q [of_pkg::NUM_PORTS][$];
   logic [of_pkg::KEY_W-1:0]     key_pool [24];
   int                           cycle_count = 0;

   openflow_datapath DUT (
      .asclk (asclk), .rst_n (rst_n),
      .s_word (s_word), .s_valid (s_valid), .s_ready (s_ready),
      .m_word (m_word), .m_valid (m_valid), .m_ready (m_ready),
      .tbl_wr (tbl_wr), .tbl_addr (tbl_addr), .tbl_entry (tbl_entry),
      .hit_count (hit_count), .miss_count (miss_count)
   );

   always #5 asclk = ~asclk;

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   `include "of_model.svh"

   always @(posedge asclk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   function automatic of_pkg::flow_entry_t make_entry(input bit valid, input int key_idx,
                                                      input int op);
      of_pkg::flow_entry_t ent;
      ent.valid           = valid;
      ent.key             = key_pool[key_idx];
      ent.action.op       = of_pkg::of_action_e'(2'(op));
      ent.action.out_port = 2'($urandom);
      ent.action.new_tag  = 16'($urandom);
      return ent;
   endfunction

   task automatic write_entry(input int addr, input of_pkg::flow_entry_t ent);
      @(posedge asclk);
      #1;
      tbl_wr          = 1'b1;
      tbl_addr        = 4'(addr);
      tbl_entry       = ent;
      model_tbl[addr] = ent;
      @(posedge asclk);
      #1;
      tbl_wr = 1'b0;
   endtask

   task automatic queue_packet(input int port);
      of_pkg::stream_word_t beats [$];
      of_pkg::stream_word_t beat;
      of_pkg::pkt_hdr_t     hdr;
      int                   len;
      len         = 1 + int'($urandom % 6);
      hdr.key     = key_pool[$urandom % 24];
      hdr.tag     = 16'($urandom);
      hdr.payload = $urandom;
      for (int w = 0; w < len; w++) begin
         beat.data = {$urandom, $urandom};
         if (w == 0) begin
            beat.data = hdr;
         end
         beat.last = (w == len - 1);
         beats.push_back(beat);
         tx_q[port].push_back(beat);
      end
      model_packet(port, beats);
   endtask

   task automatic watch_outputs();
      of_pkg::out_word_t e;
      for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
         if (m_valid[p] && m_ready[p]) begin
            if (exp_q[p].size() == 0) begin
               $display("Port %0d sent a beat at %0t when none was expected", p, $time);
               abort_run();
            end else begin
               e = exp_q[p].pop_front();
               check_val($sformatf("m_word[%0d].data", p), e.data, m_word[p].data);
               check_val($sformatf("m_word[%0d].last", p), 64'(e.last), 64'(m_word[p].last));
               check_val($sformatf("m_word[%0d].dst_port", p), 64'(e.dst_port),
                         64'(m_word[p].dst_port));
            end
         end
      end
   endtask

   function automatic bit drained();
      for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
         if (tx_q[p].size() != 0 || exp_q[p].size() != 0) begin
            return 1'b0;
         end
      end
      return (hit_count + miss_count) >= (exp_hit + exp_miss);
   endfunction

   // Sample at the falling edge, drive just after the rising edge
   task automatic run_traffic(input bit toggle_ready);
      logic [of_pkg::NUM_PORTS-1:0] fired;
      int                           settle;
      settle = 0;
      while (settle < 20) begin
         @(negedge asclk);
         fired = s_valid & s_ready;
         watch_outputs();
         @(posedge asclk);
         #1;
         for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
            if (fired[p]) begin
               void'(tx_q[p].pop_front());
            end
            s_valid[p] = (tx_q[p].size() != 0);
            if (s_valid[p]) begin
               s_word[p] = tx_q[p][0];
            end
         end
         m_ready = toggle_ready ? 4'($urandom) : '1;
         if (drained()) begin
            settle++;
         end
      end
      m_ready = '1;
   endtask

   initial begin
      void'($urandom(32'h52c5_3465));
      rst_n     = 1'b0;
      s_valid   = '0;
      m_ready   = '1;
      tbl_wr    = 1'b0;
      tbl_addr  = '0;
      tbl_entry = '0;
      exp_hit   = 0;
      exp_miss  = 0;
      for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
         s_word[p] = '0;
      end
      for (int k = 0; k < 24; k++) begin
         key_pool[k] = 16'hA000 + 16'(k * 37);
      end
      for (int e = 0; e < of_pkg::TBL_DEPTH; e++) begin
         model_tbl[e] = '0;
      end
      repeat (3) @(posedge asclk);
      #1;
      rst_n = 1'b1;
      check_val("m_valid", 64'(0), 64'(m_valid));
      check_val("s_ready", 64'({of_pkg::NUM_PORTS{1'b1}}), 64'(s_ready));
      check_val("hit_count", 64'(0), 64'(hit_count));
      check_val("miss_count", 64'(0), 64'(miss_count));

      // Keys 16 to 23 are never loaded and always miss
      for (int e = 0; e < of_pkg::TBL_DEPTH; e++) begin
         write_entry(e, make_entry(e % 5 != 4, e, e % 3));
      end
      for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
         repeat (PKTS_SOLO) queue_packet(p);
         run_traffic(1'b0);
      end

      // All ports at once under random back-pressure
      for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
         repeat (PKTS_BURST) queue_packet(p);
      end
      run_traffic(1'b1);
      check_val("hit_count", 64'(exp_hit), 64'(hit_count));
      check_val("miss_count", 64'(exp_miss), 64'(miss_count));

      // Rewritten slots may repeat keys, so first-match order matters
      for (int e = 0; e < of_pkg::TBL_DEPTH; e += 2) begin
         write_entry(e, make_entry(1'b1, int'($urandom % 24), int'($urandom % 3)));
      end
      for (int p = 0; p < of_pkg::NUM_PORTS; p++) begin
         repeat (PKTS_AFTER) queue_packet(p);
      end
      run_traffic(1'b1);
      check_val("hit_count", 64'(exp_hit), 64'(hit_count));
      check_val("miss_count", 64'(exp_miss), 64'(miss_count));

      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== src/openflow_datapath.sv ====
`timescale 1ns/1ps

module openflow_datapath (
   input  logic                          asclk,
   input  logic                          rst_n,
   input  of_pkg::stream_word_t          s_word [of_pkg::NUM_PORTS],
   input  logic [of_pkg::NUM_PORTS-1:0]  s_valid,
   output logic [of_pkg::NUM_PORTS-1:0]  s_ready,
   output of_pkg::out_word_t             m_word [of_pkg::NUM_PORTS],
   output logic [of_pkg::NUM_PORTS-1:0]  m_valid,
   input  logic [of_pkg::NUM_PORTS-1:0]  m_ready,
   input  logic                          tbl_wr,
   input  logic [of_pkg::TBL_AW-1:0]     tbl_addr,
   input  of_pkg::flow_entry_t           tbl_entry,
   output logic [of_pkg::CNT_W-1:0]      hit_count,
   output logic [of_pkg::CNT_W-1:0]      miss_count
);

   logic [of_pkg::NUM_PORTS-1:0] lu_req;
   logic [of_pkg::KEY_W-1:0]     lu_key [of_pkg::NUM_PORTS];
   logic [of_pkg::NUM_PORTS-1:0] lu_ack;
   logic [of_pkg::NUM_PORTS-1:0] lu_done;
   of_pkg::flow_action_t         lu_action;
   logic [of_pkg::NUM_PORTS-1:0] act_free;
   logic [of_pkg::NUM_PORTS-1:0] buf_pop;
   logic [of_pkg::NUM_PORTS-1:0] buf_empty;
   of_pkg::stream_word_t         buf_word [of_pkg::NUM_PORTS];

   // One ingress and one egress per port, joined by the packet buffer
   for (genvar i = 0; i < of_pkg::NUM_PORTS; i++) begin : g_port
      pkt_preprocessor u_pre (
         .asclk (asclk), .rst_n (rst_n),
         .s_word (s_word[i]), .s_valid (s_valid[i]), .s_ready (s_ready[i]),
         .lu_req (lu_req[i]), .lu_key (lu_key[i]), .lu_ack (lu_ack[i]),
         .act_free (act_free[i]),
         .pop (buf_pop[i]), .rd_word (buf_word[i]), .empty (buf_empty[i])
      );

      action_processor u_act (
         .asclk (asclk), .rst_n (rst_n),
         .lu_done (lu_done[i]), .lu_action (lu_action), .act_free (act_free[i]),
         .pop (buf_pop[i]), .rd_word (buf_word[i]), .empty (buf_empty[i]),
         .m_word (m_word[i]), .m_valid (m_valid[i]), .m_ready (m_ready[i])
      );
   end

   flow_tbl_ctrl u_ftc (
      .asclk      (asclk),
      .rst_n      (rst_n),
      .lu_req     (lu_req),
      .lu_key     (lu_key),
      .lu_ack     (lu_ack),
      .lu_done    (lu_done),
      .lu_action  (lu_action),
      .tbl_wr     (tbl_wr),
      .tbl_addr   (tbl_addr),
      .tbl_entry  (tbl_entry),
      .hit_count  (hit_count),
      .miss_count (miss_count)
   );

endmodule

// ==== src/flow_tbl_ctrl.sv ====
`timescale 1ns/1ps

module flow_tbl_ctrl (
   input  logic                          asclk,
   input  logic                          rst_n,
   input  logic [of_pkg::NUM_PORTS-1:0]  lu_req,
   input  logic [of_pkg::KEY_W-1:0]      lu_key [of_pkg::NUM_PORTS],
   output logic [of_pkg::NUM_PORTS-1:0]  lu_ack,
   output logic [of_pkg::NUM_PORTS-1:0]  lu_done,
   output of_pkg::flow_action_t          lu_action,
   input  logic                          tbl_wr,
   input  logic [of_pkg::TBL_AW-1:0]     tbl_addr,
   input  of_pkg::flow_entry_t           tbl_entry,
   output logic [of_pkg::CNT_W-1:0]      hit_count,
   output logic [of_pkg::CNT_W-1:0]      miss_count
);

   of_pkg::flow_entry_t          tbl [of_pkg::TBL_DEPTH];

   logic [of_pkg::NUM_PORTS-1:0] req_eff;
   logic [of_pkg::NUM_PORTS-1:0] ack_nxt;
   logic [of_pkg::PORT_W-1:0]    last_gnt;
   logic [of_pkg::PORT_W-1:0]    gnt_idx;
   logic [of_pkg::PORT_W-1:0]    scan_idx;
   logic                         gnt_valid;
   logic [of_pkg::KEY_W-1:0]     key_q;
   logic                         hit;
   of_pkg::flow_action_t         hit_act;

   // A port being acked this cycle still holds its request
   assign req_eff = lu_req & ~lu_ack;

   // Round robin, search starts after the last winner
   always_comb begin
      gnt_valid = 1'b0;
      gnt_idx   = last_gnt;
      scan_idx  = last_gnt;
      for (int k = 1; k <= of_pkg::NUM_PORTS; k++) begin
         scan_idx = last_gnt + k[of_pkg::PORT_W-1:0];
         if (!gnt_valid && req_eff[scan_idx]) begin
            gnt_valid = 1'b1;
            gnt_idx   = scan_idx;
         end
      end
      ack_nxt          = '0;
      ack_nxt[gnt_idx] = gnt_valid;
   end

   // Exact match, lowest valid index wins
   always_comb begin
      hit     = 1'b0;
      hit_act = '{op: of_pkg::ACT_DROP, out_port: '0, new_tag: '0};
      for (int e = 0; e < of_pkg::TBL_DEPTH; e++) begin
         if (!hit && tbl[e].valid && tbl[e].key == key_q) begin
            hit     = 1'b1;
            hit_act = tbl[e].action;
         end
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int e = 0; e < of_pkg::TBL_DEPTH; e++) begin
            tbl[e] <= '0;
         end
      end else if (tbl_wr) begin
         tbl[tbl_addr] <= tbl_entry;
      end
   end

   // Key and result are payload, only read alongside ack and done
   always_ff @(posedge asclk) begin
      key_q     <= lu_key[gnt_idx];
      lu_action <= hit_act;
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         last_gnt   <= '1;
         lu_ack     <= '0;
         lu_done    <= '0;
         hit_count  <= '0;
         miss_count <= '0;
      end else begin
         lu_ack  <= ack_nxt;
         lu_done <= lu_ack;
         if (gnt_valid) begin
            last_gnt <= gnt_idx;
         end
         if (|lu_ack) begin
            if (hit) begin
               hit_count <= hit_count + 1'b1;
            end else begin
               miss_count <= miss_count + 1'b1;
            end
         end
      end
   end

   // One grant at a time and only to a port still requesting
   a_ack_onehot: assert property (@(posedge asclk) disable iff (!rst_n)
      $onehot0(lu_ack) && ((lu_ack & ~lu_req) == '0));
   a_done_onehot: assert property (@(posedge asclk) disable iff (!rst_n) $onehot0(lu_done));

endmodule

// ==== src/action_processor.sv ====
`timescale 1ns/1ps

module action_processor (
   input  logic                  asclk,
   input  logic                  rst_n,
   input  logic                  lu_done,
   input  of_pkg::flow_action_t  lu_action,
   output logic                  act_free,
   output logic                  pop,
   input  of_pkg::stream_word_t  rd_word,
   input  logic                  empty,
   output of_pkg::out_word_t     m_word,
   output logic                  m_valid,
   input  logic                  m_ready
);

   typedef enum logic [1:0] {
      IDLE,
      SEND,
      DISCARD
   } ap_state_e;

   ap_state_e            state;
   of_pkg::flow_action_t act_q;
   logic                 first;
   of_pkg::pkt_hdr_t     hdr;

   assign act_free = (state == IDLE);
   assign m_valid  = (state == SEND) && !empty;

   always_comb begin
      case (state)
         SEND:    pop = m_valid && m_ready;
         // Drain at one word per cycle, nothing shown downstream
         DISCARD: pop = !empty;
         default: pop = 1'b0;
      endcase
   end

   // Tag rewrite applies to the header word only
   always_comb begin
      hdr = rd_word.data;
      if (first && act_q.op == of_pkg::ACT_SET_TAG) begin
         hdr.tag = act_q.new_tag;
      end
      m_word.data     = hdr;
      m_word.last     = rd_word.last;
      m_word.dst_port = act_q.out_port;
   end

   always_ff @(posedge asclk) begin
      if (lu_done) begin
         act_q <= lu_action;
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         first <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (lu_done) begin
                  first <= 1'b1;
                  if (lu_action.op == of_pkg::ACT_DROP) begin
                     state <= DISCARD;
                  end else begin
                     state <= SEND;
                  end
               end
            end
            SEND, DISCARD: begin
               if (pop) begin
                  first <= 1'b0;
                  if (rd_word.last) begin
                     state <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   a_hold_stable: assert property (@(posedge asclk) disable iff (!rst_n)
      m_valid && !m_ready |=> m_valid && $stable(m_word));

endmodule

// ==== src/pkt_preprocessor.sv ====
`timescale 1ns/1ps

module pkt_preprocessor (
   input  logic                        asclk,
   input  logic                        rst_n,
   input  of_pkg::stream_word_t        s_word,
   input  logic                        s_valid,
   output logic                        s_ready,
   output logic                        lu_req,
   output logic [of_pkg::KEY_W-1:0]    lu_key,
   input  logic                        lu_ack,
   input  logic                        act_free,
   input  logic                        pop,
   output of_pkg::stream_word_t        rd_word,
   output logic                        empty
);

   logic                     fifo_full;
   logic                     push;
   logic                     sop;
   logic                     lu_busy;
   of_pkg::pkt_hdr_t         hdr;

   // Four header slots waiting for a lookup
   logic [of_pkg::KEY_W-1:0] kq_mem [4];
   logic [1:0]               kq_wr;
   logic [1:0]               kq_rd;
   logic [2:0]               kq_cnt;
   logic                     kq_push;

   assign hdr     = s_word.data;
   assign s_ready = !fifo_full && !(sop && kq_cnt == 3'd4);
   assign push    = s_valid && s_ready;
   assign kq_push = push && sop;
   assign lu_key  = kq_mem[kq_rd];

   pkt_fifo u_fifo (
      .asclk   (asclk),
      .rst_n   (rst_n),
      .push    (push),
      .wr_word (s_word),
      .pop     (pop),
      .rd_word (rd_word),
      .empty   (empty),
      .full    (fifo_full)
   );

   always_ff @(posedge asclk) begin
      if (kq_push) begin
         kq_mem[kq_wr] <= hdr.key;
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         sop     <= 1'b1;
         kq_wr   <= '0;
         kq_rd   <= '0;
         kq_cnt  <= '0;
         lu_req  <= 1'b0;
         lu_busy <= 1'b0;
      end else begin
         if (push) begin
            sop <= s_word.last;
         end
         if (kq_push) begin
            kq_wr <= kq_wr + 1'b1;
         end
         if (lu_ack) begin
            kq_rd <= kq_rd + 1'b1;
         end
         case ({kq_push, lu_ack})
            2'b10:   kq_cnt <= kq_cnt + 1'b1;
            2'b01:   kq_cnt <= kq_cnt - 1'b1;
            default: kq_cnt <= kq_cnt;
         endcase
         // Busy from grant until the egress slot shows it took the action
         if (lu_ack) begin
            lu_req  <= 1'b0;
            lu_busy <= 1'b1;
         end else if (lu_busy && !act_free) begin
            lu_busy <= 1'b0;
         end else if (!lu_req && !lu_busy && act_free && kq_cnt != 3'd0) begin
            lu_req <= 1'b1;
         end
      end
   end

endmodule

// ==== src/pkt_fifo.sv ====
`timescale 1ns/1ps

module pkt_fifo (
   input  logic                 asclk,
   input  logic                 rst_n,
   input  logic                 push,
   input  of_pkg::stream_word_t wr_word,
   input  logic                 pop,
   output of_pkg::stream_word_t rd_word,
   output logic                 empty,
   output logic                 full
);

   of_pkg::stream_word_t mem [of_pkg::FIFO_DEPTH];

   // Pointers carry one extra wrap bit
   logic [$clog2(of_pkg::FIFO_DEPTH):0]   wr_ptr;
   logic [$clog2(of_pkg::FIFO_DEPTH):0]   rd_ptr;
   logic [$clog2(of_pkg::FIFO_DEPTH)-1:0] wr_addr;
   logic [$clog2(of_pkg::FIFO_DEPTH)-1:0] rd_addr;

   assign wr_addr = wr_ptr[$clog2(of_pkg::FIFO_DEPTH)-1:0];
   assign rd_addr = rd_ptr[$clog2(of_pkg::FIFO_DEPTH)-1:0];

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_addr == rd_addr) &&
                  (wr_ptr[$clog2(of_pkg::FIFO_DEPTH)] != rd_ptr[$clog2(of_pkg::FIFO_DEPTH)]);

   // Head word, valid one cycle after its push
   assign rd_word = mem[rd_addr];

   always_ff @(posedge asclk) begin
      if (push) begin
         mem[wr_addr] <= wr_word;
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Ingress and egress must respect the flags
   a_no_overflow: assert property (@(posedge asclk) disable iff (!rst_n) !(push && full));
   a_no_underflow: assert property (@(posedge asclk) disable iff (!rst_n) !(pop && empty));

endmodule

// ==== src/of_pkg.sv ====
package of_pkg;

   // Datapath dimensions
   localparam int NUM_PORTS  = 4;
   localparam int PORT_W     = 2;
   localparam int DATA_W     = 64;
   localparam int KEY_W      = 16;
   localparam int TAG_W      = 16;
   localparam int TBL_DEPTH  = 16;
   localparam int TBL_AW     = 4;
   localparam int FIFO_DEPTH = 32;
   localparam int CNT_W      = 32;

   typedef enum logic [1:0] {
      ACT_DROP    = 2'd0,
      ACT_FORWARD = 2'd1,
      ACT_SET_TAG = 2'd2
   } of_action_e;

   // First word of a packet, key sits in the low bits
   typedef struct packed {
      logic [DATA_W-KEY_W-TAG_W-1:0] payload;
      logic [TAG_W-1:0]              tag;
      logic [KEY_W-1:0]              key;
   } pkt_hdr_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } stream_word_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
      logic [PORT_W-1:0] dst_port;
   } out_word_t;

   typedef struct packed {
      of_action_e        op;
      logic [PORT_W-1:0] out_port;
      logic [TAG_W-1:0]  new_tag;
   } flow_action_t;

   // One exact-match table slot
   typedef struct packed {
      logic             valid;
      logic [KEY_W-1:0] key;
      flow_action_t     action;
   } flow_entry_t;

endpackage
